/* bench/decode_tests.txt */
// instr wid pc tmask | ex_type op_type xtype use_pc use_imm is_neg imm wb rd rs1 rs2 wstall
// ex_type 1 ALU, 2 LSU, 3 SFU; xtype 1 branch
003100B3 0 00001000 F 1 0 0 0 0 0 00000000 1 1 2 3 0
407302B3 1 00001004 F 1 1 0 0 0 0 00000000 1 5 6 7 0
40A4D433 2 00001008 3 1 7 0 0 0 0 00000000 1 8 9 A 0
005231B3 3 0000100C 1 1 4 0 0 0 0 00000000 1 3 4 5 0
FFF10093 0 00001010 F 1 0 0 0 1 0 FFFFFFFF 1 1 2 0 0
4032D213 1 00001014 F 1 7 0 0 1 0 00000003 1 4 5 0 0
01F39313 2 00001018 7 1 2 0 0 1 0 0000001F 1 6 7 0 0
7FF54493 3 0000101C F 1 5 0 0 1 0 000007FF 1 9 A 0 0
123452B7 0 00002000 F 1 A 0 0 1 0 12345000 1 5 0 0 0
FFFFF397 1 00002004 F 1 B 0 1 1 0 FFFFF000 1 7 0 0 0
008000EF 2 00002008 F 1 6 1 1 1 0 00000008 1 1 0 0 1
FFDFF06F 3 0000200C 8 1 6 1 1 1 0 FFFFFFFC 0 0 0 0 1
00C100E7 0 00002010 F 1 7 1 0 1 0 0000000C 1 1 2 0 1
00208863 1 00002014 F 1 0 1 1 1 0 00000010 0 0 1 2 1
FE41FCE3 2 00002018 F 1 5 1 1 1 0 FFFFFFF8 0 0 3 4 1
00039263 3 0000201C 2 1 1 1 1 1 0 00000004 0 0 7 0 1
FFC32283 0 00003000 F 2 2 0 0 1 0 FFFFFFFC 1 5 6 0 0
0030C003 1 00003004 F 2 4 0 0 1 0 00000003 0 0 1 0 0
00742A23 2 00003008 F 2 A 0 0 1 0 00000014 0 0 8 7 0
FE110FA3 3 0000300C F 2 8 0 0 1 0 FFFFFFFF 0 0 2 1 0
0FF0000F 0 00003010 F 2 F 0 0 0 0 00000000 0 0 0 0 0
00000073 1 00004000 F 1 8 1 1 1 0 00000004 0 0 0 0 1
30200073 2 00004004 F 1 C 1 1 1 0 00000004 0 0 0 0 1
00100073 3 00004008 F 1 9 1 1 1 0 00000004 0 0 0 0 1
002312F3 0 0000400C F 3 6 0 0 0 0 00006002 1 5 6 0 1
3002E0F3 1 00004010 F 3 7 0 0 1 0 00005300 1 1 0 0 0
00313073 2 00004014 F 3 8 0 0 0 0 00002003 0 0 2 0 1
0001800B 3 00005000 F 3 0 0 0 0 0 00000000 0 0 3 0 1
0052100B 0 00005004 F 3 1 0 0 0 0 00000000 0 0 4 5 1
0013A30B 1 00005008 5 3 2 0 0 0 1 00000000 1 6 7 0 1
0004300B 2 0000500C F 3 3 0 0 0 0 00000000 0 0 8 0 1
0020C00B 3 00005010 F 3 4 0 0 0 0 00000000 0 0 1 2 1
00A4D08B 0 00005014 A 3 5 0 0 0 1 00000000 0 0 9 A 1
00208033 1 00006000 F 1 0 0 0 0 0 00000000 0 0 1 2 0
00000000 2 00006004 F 0 0 0 0 0 0 00000000 0 0 0 0 0

/* filelist.f */
src/decode_pkg.sv
src/decoded_if.sv
src/imm_gen.sv
src/func_decode.sv
src/instr_decode.sv
src/decode_buffer.sv
src/decode_stage.sv
bench/decode_stage_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = decode_stage_tb
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = ERRORS FOUND

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/decode_stage_tb.sv */
/*
 * Decode stage testbench
 * Drives fetched instructions from a table file under random stalls
 * and scores the registered decode output and the scheduler notice
 */
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    localparam int fields    = 16;
    localparam int max_tests = 64;

    logic                    clk;
    logic                    rst_n;
    logic                    fetch_valid;
    logic                    fetch_ready;
    logic [instr_width-1:0]  fetch_instr;
    logic [wid_width-1:0]    fetch_wid;
    logic [pc_width-1:0]     fetch_pc;
    logic [num_threads-1:0]  fetch_tmask;
    logic                    dec_valid;
    logic                    dec_ready;
    logic [wid_width-1:0]    dec_wid;
    logic [pc_width-1:0]     dec_pc;
    logic [num_threads-1:0]  dec_tmask;
    logic [1:0]              dec_ex_type;
    logic [op_width-1:0]     dec_op_type;
    logic [1:0]              dec_xtype;
    logic                    dec_use_pc;
    logic                    dec_use_imm;
    logic                    dec_is_neg;
    logic [imm_width-1:0]    dec_imm;
    logic                    dec_wb;
    logic [reg_width-1:0]    dec_rd;
    logic [reg_width-1:0]    dec_rs1;
    logic [reg_width-1:0]    dec_rs2;
    logic                    sched_valid;
    logic [wid_width-1:0]    sched_wid;
    logic                    sched_wstall;

    // One row per test, see the column list in the data file
    logic [31:0] tests_mem [0:fields*max_tests-1];
    int          bus_idx;
    int          num_tests;
    int          received;
    int          value_errors;
    int          other_errors;
    int          exp_q[$];

    decode_stage decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] field(int t, int f);
        return tests_mem[t*fields+f];
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("error %s: got %h expected %h", name, got, exp);
                value_errors++;
            end
    endtask

    task automatic finish_run();
        $display("closing: %0d value errors, %0d other errors, %0d of %0d tests received",
                 value_errors, other_errors, received, num_tests);
        if (value_errors == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        dec_ready <= ($urandom % 4) != 0;
    end

    // Scoreboard for the scheduler notice and the decode output
    always @(posedge clk) begin
        int t;
        if (rst_n) begin
            check_value("fetch_ready", 32'(fetch_ready), 32'(!dec_valid || dec_ready));
            check_value("sched_valid", 32'(sched_valid), 32'(fetch_valid && fetch_ready));
            // Outputs belong to earlier fetches, so retire first
            if (dec_valid && dec_ready) begin
                assert (exp_q.size() > 0)
                    else begin
                        $display("decode output with no instruction outstanding");
                        other_errors++;
                    end
                if (exp_q.size() > 0) begin
                    t = exp_q.pop_front();
                    check_value("dec_wid", 32'(dec_wid), field(t, 1));
                    check_value("dec_pc", dec_pc, field(t, 2));
                    check_value("dec_tmask", 32'(dec_tmask), field(t, 3));
                    check_value("dec_ex_type", 32'(dec_ex_type), field(t, 4));
                    check_value("dec_op_type", 32'(dec_op_type), field(t, 5));
                    check_value("dec_xtype", 32'(dec_xtype), field(t, 6));
                    check_value("dec_use_pc", 32'(dec_use_pc), field(t, 7));
                    check_value("dec_use_imm", 32'(dec_use_imm), field(t, 8));
                    check_value("dec_is_neg", 32'(dec_is_neg), field(t, 9));
                    check_value("dec_imm", dec_imm, field(t, 10));
                    check_value("dec_wb", 32'(dec_wb), field(t, 11));
                    check_value("dec_rd", 32'(dec_rd), field(t, 12));
                    check_value("dec_rs1", 32'(dec_rs1), field(t, 13));
                    check_value("dec_rs2", 32'(dec_rs2), field(t, 14));
                end
                received++;
            end
            if (fetch_valid && fetch_ready) begin
                exp_q.push_back(bus_idx);
                check_value("sched_wid", 32'(sched_wid), field(bus_idx, 1));
                check_value("sched_wstall", 32'(sched_wstall), field(bus_idx, 15));
            end
        end
    end

    initial begin
        int next_idx;
        int cycles;
        int limit;
        void'($urandom(8018));
        rst_n        <= 1'b0;
        fetch_valid  <= 1'b0;
        fetch_instr  <= '0;
        fetch_wid    <= '0;
        fetch_pc     <= '0;
        fetch_tmask  <= '0;
        dec_ready    <= 1'b0;
        bus_idx      = 0;
        received     = 0;
        value_errors = 0;
        other_errors = 0;
        next_idx     = 0;
        cycles       = 0;

        // Unfilled rows read as the end marker
        for (int i = 0; i < fields*max_tests; i++) begin
            tests_mem[i] = 32'hFFFF_FFFF;
        end
        $readmemh("bench/decode_tests.txt", tests_mem);
        num_tests = 0;
        while (num_tests < max_tests && field(num_tests, 0) != 32'hFFFF_FFFF) begin
            num_tests++;
        end
        limit = num_tests * 20 + 100;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        while (received < num_tests && cycles < limit) begin
            @(posedge clk);
            cycles++;
            if (fetch_valid && fetch_ready) begin
                next_idx++;
            end
            if (fetch_valid && !fetch_ready) begin
                // Hold the offered instruction
            end else if (next_idx < num_tests && ($urandom % 5) != 0) begin
                fetch_valid <= 1'b1;
                fetch_instr <= field(next_idx, 0);
                fetch_wid   <= wid_width'(field(next_idx, 1));
                fetch_pc    <= field(next_idx, 2);
                fetch_tmask <= num_threads'(field(next_idx, 3));
                bus_idx     <= next_idx;
            end else begin
                fetch_valid <= 1'b0;
            end
        end

        // Let the scoreboard finish the last edge
        @(negedge clk);
        if (received < num_tests) begin
            $display("timeout after %0d cycles waiting for decode output", cycles);
            other_errors++;
        end
        finish_run();
    end

endmodule

/* src/decode_stage.sv */
/*
 * Instruction decode stage
 * Decodes one fetched instruction per cycle into a registered output
 * and tells the warp scheduler whether the issuing warp must stall
 */
`timescale 1ns/1ps

module decode_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                fetch_valid,
    output logic                                fetch_ready,
    input  logic [decode_pkg::instr_width-1:0]  fetch_instr,
    input  logic [decode_pkg::wid_width-1:0]    fetch_wid,
    input  logic [decode_pkg::pc_width-1:0]     fetch_pc,
    input  logic [decode_pkg::num_threads-1:0]  fetch_tmask,
    output logic                                dec_valid,
    input  logic                                dec_ready,
    output logic [decode_pkg::wid_width-1:0]    dec_wid,
    output logic [decode_pkg::pc_width-1:0]     dec_pc,
    output logic [decode_pkg::num_threads-1:0]  dec_tmask,
    output logic [1:0]                          dec_ex_type,
    output logic [decode_pkg::op_width-1:0]     dec_op_type,
    output logic [1:0]                          dec_xtype,
    output logic                                dec_use_pc,
    output logic                                dec_use_imm,
    output logic                                dec_is_neg,
    output logic [decode_pkg::imm_width-1:0]    dec_imm,
    output logic                                dec_wb,
    output logic [decode_pkg::reg_width-1:0]    dec_rd,
    output logic [decode_pkg::reg_width-1:0]    dec_rs1,
    output logic [decode_pkg::reg_width-1:0]    dec_rs2,
    output logic                                sched_valid,
    output logic [decode_pkg::wid_width-1:0]    sched_wid,
    output logic                                sched_wstall
);

    logic wstall;

    decoded_if decoded ();

    instr_decode instr_decode_i (
        .instr  (fetch_instr),
        .dec    (decoded.src),
        .wstall (wstall)
    );

    decode_buffer decode_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (fetch_valid),
        .in_ready    (fetch_ready),
        .dec         (decoded.dst),
        .ctx_wid     (fetch_wid),
        .ctx_pc      (fetch_pc),
        .ctx_tmask   (fetch_tmask),
        .out_valid   (dec_valid),
        .out_ready   (dec_ready),
        .out_wid     (dec_wid),
        .out_pc      (dec_pc),
        .out_tmask   (dec_tmask),
        .out_ex_type (dec_ex_type),
        .out_op_type (dec_op_type),
        .out_xtype   (dec_xtype),
        .out_use_pc  (dec_use_pc),
        .out_use_imm (dec_use_imm),
        .out_is_neg  (dec_is_neg),
        .out_imm     (dec_imm),
        .out_wb      (dec_wb),
        .out_rd      (dec_rd),
        .out_rs1     (dec_rs1),
        .out_rs2     (dec_rs2)
    );

    // Scheduler notice fires with the fetch handshake
    assign sched_valid  = fetch_valid && fetch_ready;
    assign sched_wid    = fetch_wid;
    assign sched_wstall = wstall;

endmodule

/* src/decode_buffer.sv */
/*
 * Decode output register
 * One-entry valid/ready pipeline stage holding a decoded instruction
 * together with its warp id, PC and thread mask
 */
`timescale 1ns/1ps

module decode_buffer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    output logic                                in_ready,
    decoded_if.dst                              dec,
    input  logic [decode_pkg::wid_width-1:0]    ctx_wid,
    input  logic [decode_pkg::pc_width-1:0]     ctx_pc,
    input  logic [decode_pkg::num_threads-1:0]  ctx_tmask,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [decode_pkg::wid_width-1:0]    out_wid,
    output logic [decode_pkg::pc_width-1:0]     out_pc,
    output logic [decode_pkg::num_threads-1:0]  out_tmask,
    output logic [1:0]                          out_ex_type,
    output logic [decode_pkg::op_width-1:0]     out_op_type,
    output logic [1:0]                          out_xtype,
    output logic                                out_use_pc,
    output logic                                out_use_imm,
    output logic                                out_is_neg,
    output logic [decode_pkg::imm_width-1:0]    out_imm,
    output logic                                out_wb,
    output logic [decode_pkg::reg_width-1:0]    out_rd,
    output logic [decode_pkg::reg_width-1:0]    out_rs1,
    output logic [decode_pkg::reg_width-1:0]    out_rs2
);
    import decode_pkg::*;

    // Empty, or the entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_wid     <= ctx_wid;
            out_pc      <= ctx_pc;
            out_tmask   <= ctx_tmask;
            out_ex_type <= dec.ex_type;
            out_op_type <= dec.op_type;
            out_xtype   <= dec.xtype;
            out_use_pc  <= dec.use_pc;
            out_use_imm <= dec.use_imm;
            out_is_neg  <= dec.is_neg;
            out_imm     <= dec.imm;
            out_wb      <= dec.wb;
            out_rd      <= dec.rd;
            out_rs1     <= dec.rs1;
            out_rs2     <= dec.rs2;
        end
    end

    hold_under_stall_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable({out_wid, out_pc, out_tmask,
            out_ex_type, out_op_type, out_xtype, out_use_pc, out_use_imm, out_is_neg,
            out_imm, out_wb, out_rd, out_rs1, out_rs2})
    ) else $error("decode output changed under back-pressure");

    empty_after_reset_a: assert property (
        @(posedge clk) !rst_n |=> !out_valid
    ) else $error("out_valid high after reset");

endmodule

/* src/instr_decode.sv */
/*
 * Main instruction decoder
 * Selects the execution unit and operation, operand sources, immediate
 * and register numbers, and flags instructions that stall the warp
 */
`timescale 1ns/1ps

module instr_decode (
    input  logic [decode_pkg::instr_width-1:0] instr,
    decoded_if.src                             dec,
    output logic                               wstall
);
    import decode_pkg::*;

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [11:0]           csr_addr;
    logic [reg_width-1:0]  rd_f;
    logic [reg_width-1:0]  rs1_f;
    logic [reg_width-1:0]  rs2_f;
    logic [imm_width-1:0]  i_imm;
    logic [imm_width-1:0]  s_imm;
    logic [imm_width-1:0]  b_imm;
    logic [imm_width-1:0]  u_imm;
    logic [imm_width-1:0]  j_imm;
    alu_op_e               alu_op;
    br_op_e                br_op;
    br_op_e                sys_op;
    logic                  use_rd;

    assign opcode   = opcode_e'(instr[opcode_msb:opcode_lsb]);
    assign funct3   = instr[funct3_msb:funct3_lsb];
    assign funct7   = instr[funct7_msb:funct7_lsb];
    assign csr_addr = instr[upper_msb:upper_lsb];
    assign rd_f     = instr[rd_msb:rd_lsb];
    assign rs1_f    = instr[rs1_msb:rs1_lsb];
    assign rs2_f    = instr[rs2_msb:rs2_lsb];

    imm_gen imm_gen_i (
        .instr (instr),
        .i_imm (i_imm),
        .s_imm (s_imm),
        .b_imm (b_imm),
        .u_imm (u_imm),
        .j_imm (j_imm)
    );

    func_decode func_decode_i (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op)
    );

    always_comb begin
        dec.ex_type = ex_none;
        dec.op_type = '0;
        dec.xtype   = xt_arith;
        dec.use_pc  = 1'b0;
        dec.use_imm = 1'b0;
        dec.is_neg  = 1'b0;
        dec.imm     = '0;
        dec.rd      = '0;
        dec.rs1     = '0;
        dec.rs2     = '0;
        use_rd      = 1'b0;
        wstall      = 1'b0;

        case (opcode)
            op_imm, op_reg: begin
                dec.ex_type = ex_alu;
                dec.op_type = alu_op;
                dec.use_imm = (opcode == op_imm);
                dec.imm     = (opcode == op_imm) ? i_imm : '0;
                use_rd      = 1'b1;
                dec.rd      = rd_f;
                dec.rs1     = rs1_f;
                dec.rs2     = (opcode == op_reg) ? rs2_f : '0;
            end
            op_lui, op_auipc: begin
                dec.ex_type = ex_alu;
                dec.op_type = (opcode == op_lui) ? alu_lui : alu_auipc;
                dec.use_pc  = (opcode == op_auipc);
                dec.use_imm = 1'b1;
                dec.imm     = u_imm;
                use_rd      = 1'b1;
                dec.rd      = rd_f;
            end
            op_jal, op_jalr, op_branch: begin
                dec.ex_type = ex_alu;
                dec.xtype   = xt_branch;
                dec.use_imm = 1'b1;
                wstall      = 1'b1;
                if (opcode == op_branch) begin
                    dec.op_type = br_op;
                    dec.use_pc  = 1'b1;
                    dec.imm     = b_imm;
                    dec.rs1     = rs1_f;
                    dec.rs2     = rs2_f;
                end else begin
                    dec.op_type = (opcode == op_jal) ? br_jal : br_jalr;
                    dec.use_pc  = (opcode == op_jal);
                    dec.imm     = (opcode == op_jal) ? j_imm : i_imm;
                    dec.rs1     = (opcode == op_jalr) ? rs1_f : '0;
                    use_rd      = 1'b1;
                    dec.rd      = rd_f;
                end
            end
            op_fence: begin
                dec.ex_type = ex_lsu;
                dec.op_type = lsu_fence;
            end
            op_load, op_store: begin
                dec.ex_type = ex_lsu;
                dec.op_type = {opcode == op_store, funct3};
                dec.use_imm = 1'b1;
                dec.imm     = (opcode == op_store) ? s_imm : i_imm;
                dec.rs1     = rs1_f;
                dec.rs2     = (opcode == op_store) ? rs2_f : '0;
                use_rd      = (opcode == op_load);
                dec.rd      = (opcode == op_load) ? rd_f : '0;
            end
            op_system: begin
                use_rd = 1'b1;
                dec.rd = rd_f;
                if (funct3[1:0] != 2'b00) begin
                    dec.ex_type = ex_sfu;
                    case (funct3[1:0])
                        2'b01:   dec.op_type = sfu_csrrw;
                        2'b10:   dec.op_type = sfu_csrrs;
                        default: dec.op_type = sfu_csrrc;
                    endcase
                    // CSR address low, uimm field above it
                    dec.use_imm = funct3[2];
                    dec.imm     = imm_width'({rs1_f, csr_addr});
                    dec.rs1     = funct3[2] ? '0 : rs1_f;
                    wstall      = (csr_addr <= csr_wstall_max);
                end else begin
                    dec.ex_type = ex_alu;
                    dec.op_type = sys_op;
                    dec.xtype   = xt_branch;
                    dec.use_pc  = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_width'(4);
                    wstall      = 1'b1;
                end
            end
            op_wctl: begin
                if (funct7 == 7'h00 && funct3 <= 3'h5) begin
                    dec.ex_type = ex_sfu;
                    dec.rs1     = rs1_f;
                    wstall      = 1'b1;
                    case (funct3)
                        3'h0: dec.op_type = sfu_tmc;
                        3'h1: dec.op_type = sfu_wspawn;
                        3'h2: dec.op_type = sfu_split;
                        3'h3: dec.op_type = sfu_join;
                        3'h4: dec.op_type = sfu_bar;
                        default: dec.op_type = sfu_pred;
                    endcase
                    dec.rs2    = (funct3 inside {3'h1, 3'h4, 3'h5}) ? rs2_f : '0;
                    use_rd     = (funct3 == 3'h2);
                    dec.rd     = (funct3 == 3'h2) ? rd_f : '0;
                    dec.is_neg = (funct3 == 3'h2) ? rs2_f[0] : (funct3 == 3'h5) && rd_f[0];
                end
            end
            default: ;
        endcase
    end

    // x0 is never written
    assign dec.wb = use_rd && (rd_f != '0);

endmodule

/* src/func_decode.sv */
/*
 * Function field decoder
 * Maps funct3, funct7 and the upper 12 bits to ALU, branch and
 * system operation codes
 */
`timescale 1ns/1ps

module func_decode (
    input  logic [decode_pkg::instr_width-1:0] instr,
    output decode_pkg::alu_op_e                alu_op,
    output decode_pkg::br_op_e                 br_op,
    output decode_pkg::br_op_e                 sys_op
);
    import decode_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] upper;

    assign opcode = instr[opcode_msb:opcode_lsb];
    assign funct3 = instr[funct3_msb:funct3_lsb];
    assign funct7 = instr[funct7_msb:funct7_lsb];
    assign upper  = instr[upper_msb:upper_lsb];

    always_comb begin
        case (funct3)
            3'h0: alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
            3'h1: alu_op = alu_sll;
            3'h2: alu_op = alu_slt;
            3'h3: alu_op = alu_sltu;
            3'h4: alu_op = alu_xor;
            3'h5: alu_op = funct7[5] ? alu_sra : alu_srl;
            3'h6: alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'h1: br_op = br_ne;
            3'h4: br_op = br_lt;
            3'h5: br_op = br_ge;
            3'h6: br_op = br_ltu;
            3'h7: br_op = br_geu;
            default: br_op = br_eq;
        endcase
    end

    // Trap and return select
    always_comb begin
        case (upper)
            12'h001: sys_op = br_ebreak;
            12'h002: sys_op = br_uret;
            12'h102: sys_op = br_sret;
            12'h302: sys_op = br_mret;
            default: sys_op = br_ecall;
        endcase
    end

    // Fetch must never hand over a branch with a reserved compare
    always_comb begin
        if (opcode == op_branch) begin
            assert (funct3 != 3'h2 && funct3 != 3'h3)
                else $error("branch with undefined funct3 %h", funct3);
        end
    end

endmodule

/* src/imm_gen.sv */
/*
 * Immediate generator
 * Builds the sign-extended I, S, B, U and J immediates of an instruction
 */
`timescale 1ns/1ps

module imm_gen (
    input  logic [decode_pkg::instr_width-1:0] instr,
    output logic [decode_pkg::imm_width-1:0]   i_imm,
    output logic [decode_pkg::imm_width-1:0]   s_imm,
    output logic [decode_pkg::imm_width-1:0]   b_imm,
    output logic [decode_pkg::imm_width-1:0]   u_imm,
    output logic [decode_pkg::imm_width-1:0]   j_imm
);
    import decode_pkg::*;

    logic [2:0]  funct3;
    logic [11:0] upper;
    logic [12:0] b_raw;
    logic [20:0] j_raw;
    logic        is_shift;

    assign funct3 = instr[funct3_msb:funct3_lsb];
    assign upper  = instr[upper_msb:upper_lsb];

    // SLLI, SRLI and SRAI carry a shift amount, not a signed value
    assign is_shift = (instr[opcode_msb:opcode_lsb] == op_imm) && funct3[0] && !funct3[1];

    assign b_raw = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_raw = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign i_imm = is_shift ? imm_width'(instr[rs2_msb:rs2_lsb])
                            : imm_width'($signed(upper));
    assign s_imm = imm_width'($signed({instr[funct7_msb:funct7_lsb], instr[rd_msb:rd_lsb]}));
    assign b_imm = imm_width'($signed(b_raw));
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = imm_width'($signed(j_raw));

endmodule

/* src/decoded_if.sv */
/*
 * Decoded instruction bundle
 * Carries unit, operation, operand flags and registers of one instruction
 */
`timescale 1ns/1ps

interface decoded_if;
    import decode_pkg::*;

    ex_type_e                ex_type;
    logic [op_width-1:0]     op_type;
    alu_xtype_e              xtype;
    logic                    use_pc;
    logic                    use_imm;
    logic                    is_neg;
    logic [imm_width-1:0]    imm;
    logic                    wb;
    logic [reg_width-1:0]    rd;
    logic [reg_width-1:0]    rs1;
    logic [reg_width-1:0]    rs2;

    modport src (output ex_type, op_type, xtype, use_pc, use_imm, is_neg, imm, wb, rd, rs1, rs2);
    modport dst (input ex_type, op_type, xtype, use_pc, use_imm, is_neg, imm, wb, rd, rs1, rs2);

endinterface

/* src/decode_pkg.sv */
/*
 * Decode stage shared definitions
 * Widths, instruction field positions, major opcodes and the
 * operation codes handed to the ALU, LSU and SFU
 */
package decode_pkg;

    localparam int instr_width = 32;
    localparam int num_warps   = 4;
    localparam int wid_width   = $clog2(num_warps);
    localparam int num_threads = 4;
    localparam int pc_width    = 32;
    localparam int reg_width   = 5;
    localparam int imm_width   = 32;
    localparam int op_width    = 4;

    // Instruction fields
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;
    localparam int rd_lsb     = 7;
    localparam int rd_msb     = 11;
    localparam int funct3_lsb = 12;
    localparam int funct3_msb = 14;
    localparam int rs1_lsb    = 15;
    localparam int rs1_msb    = 19;
    localparam int rs2_lsb    = 20;
    localparam int rs2_msb    = 24;
    localparam int funct7_lsb = 25;
    localparam int funct7_msb = 31;
    localparam int upper_lsb  = 20;
    localparam int upper_msb  = 31;

    localparam logic [op_width-1:0] lsu_fence = 4'd15;

    // CSRs up to this address stall the warp
    localparam logic [11:0] csr_wstall_max = 12'h003;

    typedef enum logic [6:0] {
        op_load   = 7'h03,
        op_wctl   = 7'h0B,
        op_fence  = 7'h0F,
        op_imm    = 7'h13,
        op_auipc  = 7'h17,
        op_store  = 7'h23,
        op_reg    = 7'h33,
        op_lui    = 7'h37,
        op_branch = 7'h63,
        op_jalr   = 7'h67,
        op_jal    = 7'h6F,
        op_system = 7'h73
    } opcode_e;

    typedef enum logic [1:0] {
        ex_none, ex_alu, ex_lsu, ex_sfu
    } ex_type_e;

    typedef enum logic [1:0] {
        xt_arith, xt_branch
    } alu_xtype_e;

    typedef enum logic [op_width-1:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_lui, alu_auipc
    } alu_op_e;

    typedef enum logic [op_width-1:0] {
        br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr,
        br_ecall, br_ebreak, br_uret, br_sret, br_mret
    } br_op_e;

    typedef enum logic [op_width-1:0] {
        sfu_tmc, sfu_wspawn, sfu_split, sfu_join, sfu_bar, sfu_pred,
        sfu_csrrw, sfu_csrrs, sfu_csrrc
    } sfu_op_e;

endpackage
